// ==== files.f ====
source/counter_pkg.sv
source/bin_ram.sv
source/pulse_counter.sv
source/counter_timer.sv
source/counter_fsm.sv
source/counter_regs.sv
source/counter_top.sv
test/tb_counter_top.sv

// ==== Bender.yml ====
package:
  name: pulse_counter

sources:
  - files:
      - source/counter_pkg.sv
      - source/bin_ram.sv
      - source/pulse_counter.sv
      - source/counter_timer.sv
      - source/counter_fsm.sv
      - source/counter_regs.sv
      - source/counter_top.sv
  - target: test
    files:
      - test/tb_counter_top.sv

// ==== test/tb_counter_top.sv ====
/*
 * Pulse counter testbench with bus tasks, xorshift pulse stimulus,
 * reference model of counts, bins and indices, assertions and watchdog
 */
`timescale 1ns/1ps

module tb_counter_top import counter_pkg::*; ();

   localparam int IMM_T  = 200;   // Immediate window timeout
   localparam int TRIG_T = 150;   // Triggered window timeout
   localparam int PRE_T  = 20;
   localparam int N_TRIG = 8;
   localparam int N_BINS = 3;
   localparam int N_REPS = 1;
   // Every window with its predelay and bus polling, plus setup and checks
   localparam int WATCHDOG_CYCLES = 3000 + IMM_T + (N_TRIG + 1) * (PRE_T + TRIG_T + 100);

   localparam logic [15:0] CFG_OFF [5] = '{REG_TIMEOUT, REG_PREDELAY, REG_BINS,
                                           REG_REPS, REG_TRIG};
   localparam logic [31:0] CFG_MASK [5] = '{32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0FFF,
                                            32'h0000_FFFF, 32'h0001_FFFF};

   logic        clk;
   logic        rstn;
   logic [3:0]  inputs;
   logic [31:0] sys_addr;
   logic [31:0] sys_wdata;
   logic        sys_wen;
   logic        sys_ren;
   logic [31:0] sys_rdata;
   logic        sys_ack;
   logic        sys_err;

   logic [31:0] rng;
   int          exp_bin [NUM_CH][N_BINS];   // Model of bins 0..2 per channel
   int          exp_bin_idx;
   int          exp_rep_idx;

   counter_top #(.NUM_INPUTS(4), .DEFAULT_TRIG_INPUT(4)) UUT (
      .i_clk(clk), .i_rstn(rstn), .i_inputs(inputs),
      .i_sys_addr(sys_addr), .i_sys_wdata(sys_wdata),
      .i_sys_wen(sys_wen), .i_sys_ren(sys_ren),
      .o_sys_rdata(sys_rdata), .o_sys_ack(sys_ack), .o_sys_err(sys_err)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
      assert (got === expected)
      else fail_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, expected));
   endtask

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Bin RAM address with the channel in bit 14
   function automatic logic [31:0] ram_addr(input int ch, input int idx);
      return 32'h0001_0000 | (32'(ch) << 14) | (32'(idx) << 2);
   endfunction

   // Single strobe that starts and ends on a falling edge
   task automatic bus_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic expect_err,
                             output logic [31:0] rdata);
      int waited;
      waited    = 0;
      sys_addr  = addr;
      sys_wdata = wdata;
      sys_wen   = write;
      sys_ren   = !write;
      @(negedge clk);
      sys_wen = 1'b0;
      sys_ren = 1'b0;
      while (!(sys_ack || sys_err) && waited < 4) begin   // RAM reads take two cycles
         waited++;
         @(negedge clk);
      end
      if (!(sys_ack || sys_err)) begin
         fail_run($sformatf("No answer to the bus request at address 0x%08h", addr));
      end else begin
         check_value("o_sys_err", 32'(sys_err), 32'(expect_err));
         check_value("o_sys_ack", 32'(sys_ack), 32'(!expect_err));
         rdata = sys_rdata;
         @(negedge clk);   // Gap between requests
      end
   endtask

   task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata);
      logic [31:0] unused;
      bus_access(1'b1, addr, wdata, 1'b0, unused);
   endtask

   task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata);
      bus_access(1'b0, addr, '0, 1'b0, rdata);
   endtask

   task automatic read_check(input string name, input logic [31:0] addr,
                             input logic [31:0] expected);
      logic [31:0] rd;
      bus_read(addr, rd);
      check_value(name, rd, expected);
   endtask

   // Pulses of 2 cycles high and 2 low on inputs 0 and 1
   task automatic drive_pulses(input int n0, input int n1);
      for (int k = 0; k < n0 || k < n1; k++) begin
         inputs[0] = (k < n0);
         inputs[1] = (k < n1);
         repeat (2) @(negedge clk);
         inputs[1:0] = 2'b00;
         repeat (2) @(negedge clk);
      end
   endtask

   task automatic wait_for_state(input state_e st, input int max_polls);
      logic [31:0] rd;
      int          polls;
      polls = 0;
      bus_read(REG_CMD, rd);
      while (rd != 32'(st) && polls < max_polls) begin
         polls++;
         bus_read(REG_CMD, rd);
      end
      if (rd != 32'(st))
         fail_run($sformatf("State did not reach %0d, still at %0d", st, rd));
   endtask

   // Accumulate, then advance repetition and bin with wrap
   task automatic model_store(input int n0, input int n1);
      exp_bin[0][exp_bin_idx] = (exp_bin[0][exp_bin_idx] + n0) % (1 << BIN_W);
      exp_bin[1][exp_bin_idx] = (exp_bin[1][exp_bin_idx] + n1) % (1 << BIN_W);
      if (exp_rep_idx == N_REPS) begin
         exp_rep_idx = 0;
         exp_bin_idx = (exp_bin_idx == N_BINS - 1) ? 0 : exp_bin_idx + 1;
      end else begin
         exp_rep_idx++;
      end
   endtask

   task automatic check_bins();
      for (int c = 0; c < NUM_CH; c++)
         for (int b = 0; b < N_BINS; b++)
            read_check($sformatf("o_sys_rdata bin %0d ch %0d", b, c), ram_addr(c, b),
                       exp_bin[c][b]);
      read_check("REG_BIN_IDX", REG_BIN_IDX, exp_bin_idx);
      read_check("REG_REP_IDX", REG_REP_IDX, exp_rep_idx);
   endtask

   ack_err_exclusive: assert property (@(posedge clk) disable iff (!rstn)
      !(sys_ack && sys_err))
      else fail_run("Bus answered with ack and err together");

   answer_is_pulse: assert property (@(posedge clk) disable iff (!rstn)
      (sys_ack || sys_err) |=> !(sys_ack || sys_err))
      else fail_run("Bus answer lasted longer than one cycle");

   idle_not_counting: assert property (@(posedge clk) disable iff (!rstn)
      UUT.state == ST_IDLE |-> !UUT.counting)
      else fail_run("Counting enable was high in the idle state");

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      fail_run($sformatf("Watchdog expired after %0d cycles", WATCHDOG_CYCLES));
   end

   initial begin
      logic [31:0]      rd;
      logic [BIN_W-1:0] ram_data [8];
      int               n0;
      int               n1;

      rng         = 32'd50462;
      rstn        = 1'b0;
      inputs      = '0;
      sys_addr    = '0;
      sys_wdata   = '0;
      sys_wen     = 1'b0;
      sys_ren     = 1'b0;
      exp_bin_idx = 0;
      exp_rep_idx = 0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);

      // Defaults, read-back and error answers
      read_check("REG_TRIG", REG_TRIG, 32'h0001_0008);   // Mask bit 3, polarity 1
      read_check("REG_CMD", REG_CMD, ST_IDLE);
      for (int i = 0; i < 5; i++) begin
         rng = xorshift(rng);
         bus_write(CFG_OFF[i], rng);
         read_check($sformatf("register 0x%02h", CFG_OFF[i]), CFG_OFF[i], rng & CFG_MASK[i]);
      end
      bus_access(1'b0, 32'h0000_0028, '0, 1'b1, rd);
      bus_access(1'b1, REG_LAST0, 32'h1, 1'b1, rd);   // Read-only
      bus_access(1'b0, 32'h0002_0000, '0, 1'b1, rd);

      // Immediate window
      bus_write(REG_TIMEOUT, IMM_T);
      rng = xorshift(rng);
      n0  = 1 + rng % 15;
      rng = xorshift(rng);
      n1  = 1 + rng % 15;
      bus_write(REG_CMD, CMD_COUNT_IMM);
      repeat (10) @(negedge clk);
      drive_pulses(n0, n1);
      wait_for_state(ST_IDLE, IMM_T);
      read_check("REG_LAST0", REG_LAST0, n0);
      read_check("REG_LAST1", REG_LAST1, n1);

      // Triggered windows into 3 bins on rising edges of input 2
      for (int c = 0; c < NUM_CH; c++)
         for (int b = 0; b < N_BINS; b++) begin
            bus_write(ram_addr(c, b), 32'h0);
            exp_bin[c][b] = 0;
         end
      bus_write(REG_TIMEOUT, TRIG_T);
      bus_write(REG_PREDELAY, PRE_T);
      bus_write(REG_BINS, N_BINS);
      bus_write(REG_REPS, N_REPS);
      bus_write(REG_TRIG, 32'h0000_0404);
      bus_write(REG_CMD, CMD_COUNT_TRIG);
      wait_for_state(ST_TRIG_WAIT, 10);
      for (int m = 0; m < N_TRIG; m++) begin
         rng       = xorshift(rng);
         n0        = 1 + rng % 15;
         rng       = xorshift(rng);
         n1        = 1 + rng % 15;
         inputs[2] = 1'b1;
         repeat (40) @(negedge clk);   // Past the predelay
         drive_pulses(n0, n1);
         inputs[2] = 1'b0;
         wait_for_state(ST_TRIG_WAIT, TRIG_T);
         model_store(n0, n1);
         read_check("REG_LAST0", REG_LAST0, n0);
         read_check("REG_LAST1", REG_LAST1, n1);
         read_check("REG_BIN_IDX", REG_BIN_IDX, exp_bin_idx);
         read_check("REG_REP_IDX", REG_REP_IDX, exp_rep_idx);
      end
      check_bins();

      // Software trigger without predelay
      bus_write(REG_PREDELAY, 0);
      rng = xorshift(rng);
      n0  = 1 + rng % 15;
      rng = xorshift(rng);
      n1  = 1 + rng % 15;
      bus_write(REG_CMD, CMD_TRIGGER);
      repeat (10) @(negedge clk);
      drive_pulses(n0, n1);
      wait_for_state(ST_TRIG_WAIT, TRIG_T);
      model_store(n0, n1);
      check_bins();

      // Bus access to both RAMs
      for (int k = 0; k < 8; k++) begin
         rng         = xorshift(rng);
         ram_data[k] = rng[BIN_W-1:0];
         bus_write(ram_addr(k % 2, 100 + k), ram_data[k]);
      end
      for (int k = 0; k < 8; k++)
         read_check($sformatf("o_sys_rdata RAM word %0d", k), ram_addr(k % 2, 100 + k),
                    ram_data[k]);

      // Reset command clears both indices
      bus_write(REG_CMD, CMD_RESET);
      read_check("REG_CMD", REG_CMD, ST_IDLE);
      read_check("REG_BIN_IDX", REG_BIN_IDX, 0);
      read_check("REG_REP_IDX", REG_REP_IDX, 0);

      $display("Simulation PASSED");
      $finish;
   end

endmodule

// ==== source/counter_top.sv ====
/*
 * Pulse counter top level, register file, FSM, timer,
 * per-channel pulse counters and bin RAMs
 */
`timescale 1ns/1ps

module counter_top import counter_pkg::*; #(
   parameter int NUM_INPUTS         = 4,
   parameter int DEFAULT_TRIG_INPUT = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rstn,
   input  logic [NUM_INPUTS-1:0] i_inputs,
   input  logic [DATA_W-1:0]     i_sys_addr,
   input  logic [DATA_W-1:0]     i_sys_wdata,
   input  logic                  i_sys_wen,
   input  logic                  i_sys_ren,
   output logic [DATA_W-1:0]     o_sys_rdata,
   output logic                  o_sys_ack,
   output logic                  o_sys_err
);

   cmd_e                  cmd;
   logic                  cmd_valid;
   logic [DATA_W-1:0]     timeout;
   logic [DATA_W-1:0]     predelay;
   logic [BIN_ADDR_W-1:0] bins_in_use;
   logic [REP_W-1:0]      bin_reps;
   logic [TRIG_W-1:0]     trig_mask;
   logic [TRIG_W-1:0]     trig_invert;
   logic                  trig_polarity;
   state_e                state;
   logic [DATA_W-1:0]     last_count [NUM_CH];
   logic [BIN_ADDR_W-1:0] bin_index;
   logic [REP_W-1:0]      rep_index;
   logic                  timer_load;
   logic [DATA_W-1:0]     timer_value;
   logic                  timer_expired;
   logic                  counting;
   logic [DATA_W-1:0]     count [NUM_CH];
   logic                  fsm_ram_we;
   logic [BIN_W-1:0]      fsm_ram_wdata [NUM_CH];
   logic [BIN_W-1:0]      fsm_ram_rdata [NUM_CH];
   logic [BIN_ADDR_W-1:0] bus_ram_addr;
   logic [NUM_CH-1:0]     bus_ram_we;
   logic [BIN_W-1:0]      bus_ram_wdata;
   logic [BIN_W-1:0]      bus_ram_rdata [NUM_CH];

   counter_regs #(.DEFAULT_TRIG_INPUT(DEFAULT_TRIG_INPUT)) u_regs (
      .i_clk, .i_rstn, .i_sys_addr, .i_sys_wdata, .i_sys_wen, .i_sys_ren,
      .o_sys_rdata, .o_sys_ack, .o_sys_err,
      .o_cmd(cmd), .o_cmd_valid(cmd_valid),
      .o_timeout(timeout), .o_predelay(predelay), .o_bins_in_use(bins_in_use),
      .o_bin_reps(bin_reps), .o_trig_mask(trig_mask), .o_trig_invert(trig_invert),
      .o_trig_polarity(trig_polarity),
      .i_state(state), .i_last_count(last_count), .i_bin_index(bin_index),
      .i_rep_index(rep_index),
      .o_ram_addr(bus_ram_addr), .o_ram_we(bus_ram_we), .o_ram_wdata(bus_ram_wdata),
      .i_ram_rdata(bus_ram_rdata)
   );

   counter_fsm #(.NUM_INPUTS(NUM_INPUTS)) u_fsm (
      .i_clk, .i_rstn, .i_inputs,
      .i_cmd(cmd), .i_cmd_valid(cmd_valid),
      .i_timeout(timeout), .i_predelay(predelay), .i_bins_in_use(bins_in_use),
      .i_bin_reps(bin_reps), .i_trig_mask(trig_mask), .i_trig_invert(trig_invert),
      .i_trig_polarity(trig_polarity), .i_timer_expired(timer_expired),
      .i_count(count), .i_ram_rdata(fsm_ram_rdata),
      .o_timer_load(timer_load), .o_timer_value(timer_value), .o_counting(counting),
      .o_state(state), .o_last_count(last_count), .o_bin_index(bin_index),
      .o_rep_index(rep_index), .o_ram_we(fsm_ram_we), .o_ram_wdata(fsm_ram_wdata)
   );

   counter_timer u_timer (
      .i_clk, .i_rstn,
      .i_load(timer_load), .i_value(timer_value), .o_expired(timer_expired)
   );

   // Channel c counts input c and owns bin RAM c
   for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
      pulse_counter u_pulse (
         .i_clk, .i_rstn,
         .i_signal(i_inputs[c]), .i_enable(counting), .o_count(count[c])
      );

      bin_ram u_ram (
         .i_clk,
         .i_addr_a(bin_index), .i_we_a(fsm_ram_we), .i_wdata_a(fsm_ram_wdata[c]),
         .o_rdata_a(fsm_ram_rdata[c]),
         .i_addr_b(bus_ram_addr), .i_we_b(bus_ram_we[c]), .i_wdata_b(bus_ram_wdata),
         .o_rdata_b(bus_ram_rdata[c])
      );
   end

endmodule

// ==== source/counter_regs.sv ====
/*
 * Bus decode, configuration registers, read-back mux
 * and bus access to the bin RAMs
 */
`timescale 1ns/1ps

module counter_regs import counter_pkg::*; #(
   parameter int DEFAULT_TRIG_INPUT = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rstn,
   input  logic [DATA_W-1:0]     i_sys_addr,
   input  logic [DATA_W-1:0]     i_sys_wdata,
   input  logic                  i_sys_wen,
   input  logic                  i_sys_ren,
   output logic [DATA_W-1:0]     o_sys_rdata,
   output logic                  o_sys_ack,
   output logic                  o_sys_err,
   output cmd_e                  o_cmd,
   output logic                  o_cmd_valid,
   output logic [DATA_W-1:0]     o_timeout,
   output logic [DATA_W-1:0]     o_predelay,
   output logic [BIN_ADDR_W-1:0] o_bins_in_use,
   output logic [REP_W-1:0]      o_bin_reps,
   output logic [TRIG_W-1:0]     o_trig_mask,
   output logic [TRIG_W-1:0]     o_trig_invert,
   output logic                  o_trig_polarity,
   input  state_e                i_state,
   input  logic [DATA_W-1:0]     i_last_count [NUM_CH],
   input  logic [BIN_ADDR_W-1:0] i_bin_index,
   input  logic [REP_W-1:0]      i_rep_index,
   output logic [BIN_ADDR_W-1:0] o_ram_addr,
   output logic [NUM_CH-1:0]     o_ram_we,
   output logic [BIN_W-1:0]      o_ram_wdata,
   input  logic [BIN_W-1:0]      i_ram_rdata [NUM_CH]
);

   bus_addr_u         addr;
   logic              req;
   logic              reg_sel;
   logic              ram_sel;
   logic              ram_rd_pend;   // RAM read issued, data next cycle
   logic              ram_rd_ack;
   logic              ram_ch;
   logic [DATA_W-1:0] rdata_q;

   assign addr    = i_sys_addr;
   assign req     = i_sys_wen | i_sys_ren;
   assign reg_sel = req && addr.regs.upper == '0 && addr.regs.region == REGION_REG;
   assign ram_sel = req && addr.ram.upper == '0 && addr.ram.region == REGION_RAM &&
                    !addr.ram.rsvd && addr.ram.byte_sel == 2'b00;

   // RAM words are zero-extended
   assign o_sys_rdata = ram_rd_ack ? DATA_W'(i_ram_rdata[ram_ch]) : rdata_q;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_sys_ack       <= 1'b0;
         o_sys_err       <= 1'b0;
         o_cmd           <= CMD_NONE;
         o_cmd_valid     <= 1'b0;
         o_ram_we        <= '0;
         ram_rd_pend     <= 1'b0;
         ram_rd_ack      <= 1'b0;
         o_timeout       <= '0;
         o_predelay      <= '0;
         o_bins_in_use   <= '0;
         o_bin_reps      <= '0;
         o_trig_mask     <= TRIG_W'(1) << (DEFAULT_TRIG_INPUT - 1);
         o_trig_invert   <= '0;
         o_trig_polarity <= 1'b1;
      end else begin
         o_sys_ack   <= ram_rd_pend;   // Delayed answer of a RAM read
         o_sys_err   <= 1'b0;
         o_cmd_valid <= 1'b0;
         o_ram_we    <= '0;
         ram_rd_pend <= 1'b0;
         ram_rd_ack  <= ram_rd_pend;

         if (reg_sel && i_sys_wen) begin
            o_sys_ack <= 1'b1;
            case (addr.regs.offset)
               REG_CMD: begin
                  o_cmd       <= cmd_e'(i_sys_wdata[2:0]);
                  o_cmd_valid <= 1'b1;
               end
               REG_TIMEOUT:  o_timeout     <= i_sys_wdata;
               REG_BINS:     o_bins_in_use <= i_sys_wdata[BIN_ADDR_W-1:0];
               REG_REPS:     o_bin_reps    <= i_sys_wdata[REP_W-1:0];
               REG_PREDELAY: o_predelay    <= i_sys_wdata;
               REG_TRIG: begin
                  o_trig_mask     <= i_sys_wdata[TRIG_W-1:0];
                  o_trig_invert   <= i_sys_wdata[2*TRIG_W-1:TRIG_W];
                  o_trig_polarity <= i_sys_wdata[2*TRIG_W];
               end
               default: begin   // Read-only or unmapped
                  o_sys_ack <= 1'b0;
                  o_sys_err <= 1'b1;
               end
            endcase
         end else if (reg_sel) begin
            o_sys_ack <= 1'b1;
            case (addr.regs.offset)
               REG_CMD:      rdata_q <= DATA_W'(i_state);
               REG_TIMEOUT:  rdata_q <= o_timeout;
               REG_LAST0:    rdata_q <= i_last_count[0];
               REG_LAST1:    rdata_q <= i_last_count[1];
               REG_BINS:     rdata_q <= DATA_W'(o_bins_in_use);
               REG_REPS:     rdata_q <= DATA_W'(o_bin_reps);
               REG_PREDELAY: rdata_q <= o_predelay;
               REG_TRIG:     rdata_q <= DATA_W'({o_trig_polarity, o_trig_invert, o_trig_mask});
               REG_BIN_IDX:  rdata_q <= DATA_W'(i_bin_index);
               REG_REP_IDX:  rdata_q <= DATA_W'(i_rep_index);
               default: begin
                  o_sys_ack <= 1'b0;
                  o_sys_err <= 1'b1;
               end
            endcase
         end else if (ram_sel) begin
            if (i_sys_wen) begin
               o_ram_we[addr.ram.ch] <= 1'b1;
               o_sys_ack             <= 1'b1;
            end else begin
               ram_rd_pend <= 1'b1;
            end
         end else if (req) begin
            o_sys_err <= 1'b1;
         end
      end
   end

   // Port B address and data, no reset
   always_ff @(posedge i_clk) begin
      if (ram_sel) begin
         o_ram_addr  <= addr.ram.bin_addr;
         o_ram_wdata <= i_sys_wdata[BIN_W-1:0];
         ram_ch      <= addr.ram.ch;
      end
   end

   a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rstn)
      !(o_sys_ack && o_sys_err));

endmodule

// ==== source/counter_fsm.sv ====
/*
 * Trigger evaluation, counting state machine,
 * bin accumulation and bin/repetition indexing
 */
`timescale 1ns/1ps

module counter_fsm import counter_pkg::*; #(
   parameter int NUM_INPUTS = 4
) (
   input  logic                  i_clk,
   input  logic                  i_rstn,
   input  logic [NUM_INPUTS-1:0] i_inputs,
   input  cmd_e                  i_cmd,
   input  logic                  i_cmd_valid,
   input  logic [DATA_W-1:0]     i_timeout,
   input  logic [DATA_W-1:0]     i_predelay,
   input  logic [BIN_ADDR_W-1:0] i_bins_in_use,
   input  logic [REP_W-1:0]      i_bin_reps,
   input  logic [TRIG_W-1:0]     i_trig_mask,
   input  logic [TRIG_W-1:0]     i_trig_invert,
   input  logic                  i_trig_polarity,
   input  logic                  i_timer_expired,
   input  logic [DATA_W-1:0]     i_count [NUM_CH],
   input  logic [BIN_W-1:0]      i_ram_rdata [NUM_CH],
   output logic                  o_timer_load,
   output logic [DATA_W-1:0]     o_timer_value,
   output logic                  o_counting,
   output state_e                o_state,
   output logic [DATA_W-1:0]     o_last_count [NUM_CH],
   output logic [BIN_ADDR_W-1:0] o_bin_index,
   output logic [REP_W-1:0]      o_rep_index,
   output logic                  o_ram_we,
   output logic [BIN_W-1:0]      o_ram_wdata [NUM_CH]
);

   logic [NUM_INPUTS-1:0] in_meta;
   logic [NUM_INPUTS-1:0] in_sync;
   logic [TRIG_W-1:0]     trig_in;
   logic                  trig_level;
   logic                  trig_prev;
   logic                  trig_go;   // Input edge or software trigger

   always_ff @(posedge i_clk) begin
      in_meta <= i_inputs;
      in_sync <= in_meta;
   end

   assign trig_in    = TRIG_W'(in_sync);
   assign trig_level = (|((trig_in ^ i_trig_invert) & i_trig_mask)) == i_trig_polarity;
   assign trig_go    = (trig_level && !trig_prev) || (i_cmd_valid && i_cmd == CMD_TRIGGER);

   // Timer load for window and predelay
   always_comb begin
      o_timer_load  = 1'b0;
      o_timer_value = i_timeout;
      case (o_state)
         ST_IMM_START: o_timer_load = 1'b1;
         ST_TRIG_WAIT: begin
            o_timer_load = trig_go;
            if (i_predelay != '0)
               o_timer_value = i_predelay - 1'b1;
         end
         ST_TRIG_PREDELAY: o_timer_load = i_timer_expired;
         default: o_timer_load = 1'b0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         o_state     <= ST_IDLE;
         o_counting  <= 1'b0;
         o_bin_index <= '0;
         o_rep_index <= '0;
         trig_prev   <= 1'b1;   // No edge right after reset
      end else begin
         trig_prev <= trig_level;
         if (i_cmd_valid && i_cmd inside {CMD_GOTO_IDLE, CMD_RESET, CMD_COUNT_IMM,
                                          CMD_COUNT_TRIG}) begin
            o_counting <= 1'b0;
            case (i_cmd)
               CMD_COUNT_IMM:  o_state <= ST_IMM_START;
               CMD_COUNT_TRIG: o_state <= ST_TRIG_WAIT;
               default:        o_state <= ST_IDLE;
            endcase
            if (i_cmd == CMD_RESET) begin
               o_bin_index <= '0;
               o_rep_index <= '0;
            end
         end else begin
            case (o_state)
               ST_IMM_START: begin
                  o_counting <= 1'b1;
                  o_state    <= ST_IMM_COUNT;
               end
               ST_IMM_COUNT: if (i_timer_expired) begin
                  o_counting <= 1'b0;
                  o_state    <= ST_IDLE;
               end
               ST_TRIG_WAIT: if (trig_go) begin
                  if (i_predelay != '0) begin
                     o_state <= ST_TRIG_PREDELAY;
                  end else begin
                     o_counting <= 1'b1;
                     o_state    <= ST_TRIG_COUNT;
                  end
               end
               ST_TRIG_PREDELAY: if (i_timer_expired) begin
                  o_counting <= 1'b1;
                  o_state    <= ST_TRIG_COUNT;
               end
               ST_TRIG_COUNT: if (i_timer_expired) begin
                  o_counting <= 1'b0;
                  o_state    <= ST_TRIG_PRESTORE;
               end
               ST_TRIG_PRESTORE: o_state <= ST_TRIG_STORE;
               ST_TRIG_STORE: begin
                  if (o_rep_index == i_bin_reps) begin
                     o_rep_index <= '0;
                     if (o_bin_index == i_bins_in_use - 1'b1)
                        o_bin_index <= '0;
                     else
                        o_bin_index <= o_bin_index + 1'b1;
                  end else begin
                     o_rep_index <= o_rep_index + 1'b1;
                  end
                  o_state <= ST_TRIG_WAIT;
               end
               default: o_state <= ST_IDLE;
            endcase
         end
      end
   end

   // Last counts at the final window cycle
   always_ff @(posedge i_clk) begin
      if (i_timer_expired && (o_state == ST_IMM_COUNT || o_state == ST_TRIG_COUNT))
         o_last_count <= i_count;
   end

   // Read-modify-write, port A reads the current bin all along
   assign o_ram_we = (o_state == ST_TRIG_PRESTORE);

   always_comb begin
      for (int c = 0; c < NUM_CH; c++)
         o_ram_wdata[c] = i_ram_rdata[c] + o_last_count[c][BIN_W-1:0];   // Wraps at 2^18
   end

   a_we_after_count: assert property (@(posedge i_clk) disable iff (!i_rstn)
      o_ram_we |-> o_state == ST_TRIG_PRESTORE && $past(o_state) == ST_TRIG_COUNT);

   a_bin_in_range: assert property (@(posedge i_clk) disable iff (!i_rstn)
      o_state == ST_TRIG_STORE && i_bins_in_use != '0 |=> o_bin_index < i_bins_in_use);

endmodule

// ==== source/counter_timer.sv ====
/*
 * Loadable down-counter for predelay and counting window
 */
`timescale 1ns/1ps

module counter_timer import counter_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rstn,
   input  logic              i_load,
   input  logic [DATA_W-1:0] i_value,
   output logic              o_expired
);

   logic [DATA_W-1:0] count;

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         count <= '0;
      end else if (i_load) begin
         count <= i_value;
      end else if (count != '0) begin
         count <= count - 1'b1;   // Holds at zero
      end
   end

   assign o_expired = (count == '0);

   a_no_wrap: assert property (@(posedge i_clk) disable iff (!i_rstn)
      !i_load && count == '0 |=> count == '0);

endmodule

// ==== source/pulse_counter.sv ====
/*
 * Input synchronizer and rising-edge counter with clear
 */
`timescale 1ns/1ps

module pulse_counter import counter_pkg::*; (
   input  logic              i_clk,
   input  logic              i_rstn,
   input  logic              i_signal,
   input  logic              i_enable,
   output logic [DATA_W-1:0] o_count
);

   logic sync_meta;
   logic sync_q;
   logic sync_prev;   // For edge detection

   always_ff @(posedge i_clk) begin
      sync_meta <= i_signal;
      sync_q    <= sync_meta;
   end

   always_ff @(posedge i_clk) begin
      if (!i_rstn) begin
         sync_prev <= 1'b0;
         o_count   <= '0;
      end else begin
         sync_prev <= sync_q;
         if (!i_enable)
            o_count <= '0;   // Clear while idle
         else if (sync_q && !sync_prev)
            o_count <= o_count + 1'b1;
      end
   end

endmodule

// ==== source/bin_ram.sv ====
/*
 * True dual-port RAM of 4096 18-bit bins, registered reads
 */
`timescale 1ns/1ps

module bin_ram import counter_pkg::*; (
   input  logic                  i_clk,
   input  logic [BIN_ADDR_W-1:0] i_addr_a,
   input  logic                  i_we_a,
   input  logic [BIN_W-1:0]      i_wdata_a,
   output logic [BIN_W-1:0]      o_rdata_a,
   input  logic [BIN_ADDR_W-1:0] i_addr_b,
   input  logic                  i_we_b,
   input  logic [BIN_W-1:0]      i_wdata_b,
   output logic [BIN_W-1:0]      o_rdata_b
);

   logic [BIN_W-1:0] mem [2**BIN_ADDR_W];

   always_ff @(posedge i_clk) begin
      if (i_we_b)
         mem[i_addr_b] <= i_wdata_b;
      if (i_we_a)
         mem[i_addr_a] <= i_wdata_a;   // Port A wins on a collision
      o_rdata_a <= mem[i_addr_a];
      o_rdata_b <= mem[i_addr_b];
   end

endmodule

// ==== source/counter_pkg.sv ====
/*
 * Shared widths, register offsets, command and state codes,
 * and the bus address union of the pulse counter
 */
package counter_pkg;

   localparam int DATA_W     = 32;
   localparam int BIN_W      = 18;
   localparam int BIN_ADDR_W = 12;   // 4096 bins
   localparam int REP_W      = 16;
   localparam int TRIG_W     = 8;
   localparam int NUM_CH     = 2;    // RAM select is one address bit

   // Register offsets within region 0
   localparam logic [15:0] REG_CMD      = 16'h0000;
   localparam logic [15:0] REG_TIMEOUT  = 16'h0004;
   localparam logic [15:0] REG_LAST0    = 16'h0008;
   localparam logic [15:0] REG_LAST1    = 16'h000C;
   localparam logic [15:0] REG_BINS     = 16'h0010;
   localparam logic [15:0] REG_REPS     = 16'h0014;
   localparam logic [15:0] REG_PREDELAY = 16'h0018;
   localparam logic [15:0] REG_TRIG     = 16'h001C;
   localparam logic [15:0] REG_BIN_IDX  = 16'h0020;
   localparam logic [15:0] REG_REP_IDX  = 16'h0024;

   localparam logic [3:0] REGION_REG = 4'h0;
   localparam logic [3:0] REGION_RAM = 4'h1;   // 0x10000 ch0, 0x14000 ch1

   typedef enum logic [2:0] {
      CMD_NONE       = 3'd0,
      CMD_GOTO_IDLE  = 3'd1,
      CMD_RESET      = 3'd2,
      CMD_COUNT_IMM  = 3'd3,
      CMD_COUNT_TRIG = 3'd4,
      CMD_TRIGGER    = 3'd6
   } cmd_e;

   typedef enum logic [2:0] {
      ST_IDLE          = 3'd0,
      ST_IMM_START     = 3'd1,
      ST_IMM_COUNT     = 3'd2,
      ST_TRIG_WAIT     = 3'd3,
      ST_TRIG_STORE    = 3'd4,
      ST_TRIG_PREDELAY = 3'd5,
      ST_TRIG_PRESTORE = 3'd6,
      ST_TRIG_COUNT    = 3'd7
   } state_e;

   typedef struct packed {
      logic [11:0] upper;
      logic [3:0]  region;
      logic [15:0] offset;
   } reg_view_t;

   typedef struct packed {
      logic [11:0]           upper;
      logic [3:0]            region;
      logic                  rsvd;
      logic                  ch;        // Bin RAM select
      logic [BIN_ADDR_W-1:0] bin_addr;
      logic [1:0]            byte_sel;
   } ram_view_t;

   typedef union packed {
      reg_view_t regs;
      ram_view_t ram;
   } bus_addr_u;

endpackage
